// File: files.f
hw/kv_defines_pkg.sv
hw/kv_reg_pkg.sv
hw/kv_store.sv
hw/kv_fsm.sv
hw/kv_read_client.sv
hw/kv_client_regs.sv
hw/kv_subsys_top.sv
tests/kv_tb_clk.sv
tests/kv_subsys_tb.sv

// File: hw/kv_client_regs.sv
// key vault register block, AXI4-Lite slave
// control, status, lock and key load registers plus the
// destination buffer filled by the read client
`timescale 1ns/1ps

module kv_client_regs
    import kv_defines_pkg::*;
    import kv_reg_pkg::*;
#(
    parameter int DATA_WIDTH  = 384,
    parameter int NUM_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst_b,
    input  logic [AXI_ADDR_W-1:0]  awaddr,
    input  logic                   awvalid,
    output logic                   awready,
    input  logic [31:0]            wdata,
    input  logic [3:0]             wstrb,
    input  logic                   wvalid,
    output logic                   wready,
    output logic [1:0]             bresp,
    output logic                   bvalid,
    input  logic                   bready,
    input  logic [AXI_ADDR_W-1:0]  araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output logic [31:0]            rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  logic                   rready,
    output kv_read_ctrl_reg_t      read_ctrl_reg,
    input  logic                   write_en,
    input  logic [3:0]             write_offset,
    input  logic [31:0]            write_data,
    input  kv_error_code_e         error_code,
    input  logic                   kv_ready,
    input  logic                   read_done,
    output logic                   key_we,
    output logic [2:0]             key_entry,
    output logic [3:0]             key_offset,
    output logic [31:0]            key_data,
    output logic [NUM_ENTRIES-1:0] lock_mask
);

    localparam int NUM_DWORDS = DATA_WIDTH / 32;

    logic [31:0] dest_buf [NUM_DWORDS];

    logic                   wr_fire;
    logic                   rd_fire;
    logic                   busy;
    logic                   done_q;
    logic [31:0]            wmask;
    logic [31:0]            ctrl_rd;
    logic [31:0]            ctrl_new;
    logic [31:0]            key_addr_rd;
    logic [31:0]            key_addr_new;
    logic [31:0]            lock_new;
    logic [31:0]            rdata_d;
    logic [AXI_ADDR_W-1:0]  dest_off;
    logic                   dest_hit;

    // both write channels must be present, one response outstanding
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign rd_fire = arvalid && !rvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = rd_fire;
    assign rresp   = AXI_RESP_OKAY;

    // start pulse still counts as running
    assign busy = read_ctrl_reg.read_en || !kv_ready;

    assign wmask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};

    // current register contents, merged with strobed write bytes
    always_comb begin
        ctrl_rd = '0;
        ctrl_rd[CTRL_PCR_BIT] = read_ctrl_reg.entry_is_pcr;
        ctrl_rd[CTRL_ENTRY_LSB +: 3] = read_ctrl_reg.read_entry;
        ctrl_rd[CTRL_SIZE_LSB +: 4] = read_ctrl_reg.entry_data_size;
        key_addr_rd = '0;
        key_addr_rd[KEY_ENTRY_LSB +: 3] = key_entry;
        key_addr_rd[3:0] = key_offset;
        lock_new = '0;
        lock_new[NUM_ENTRIES-1:0] = lock_mask;
        ctrl_new     = (ctrl_rd & ~wmask) | (wdata & wmask);
        key_addr_new = (key_addr_rd & ~wmask) | (wdata & wmask);
        lock_new     = (lock_new & ~wmask) | (wdata & wmask);
    end

    // key dword goes straight to the vault port
    assign key_we   = wr_fire && (awaddr == REG_KEY_DATA);
    assign key_data = wdata & wmask;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            read_ctrl_reg <= '0;
            key_entry     <= '0;
            key_offset    <= '0;
            lock_mask     <= '0;
            done_q        <= 1'b0;
            bvalid        <= 1'b0;
            bresp         <= AXI_RESP_OKAY;
        end else begin
            read_ctrl_reg.read_en <= 1'b0;
            if (read_done) begin
                done_q <= 1'b1;
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (wr_fire) begin
                bvalid <= 1'b1;
                bresp  <= AXI_RESP_OKAY;
                case (awaddr)
                    REG_CTRL: begin
                        if (busy) begin
                            // running read keeps its control word
                            bresp <= AXI_RESP_SLVERR;
                        end else begin
                            read_ctrl_reg.entry_is_pcr    <= ctrl_new[CTRL_PCR_BIT];
                            read_ctrl_reg.read_entry      <= ctrl_new[CTRL_ENTRY_LSB +: 3];
                            read_ctrl_reg.entry_data_size <= ctrl_new[CTRL_SIZE_LSB +: 4];
                            if (wstrb[0] && wdata[CTRL_START_BIT]) begin
                                read_ctrl_reg.read_en <= 1'b1;
                                done_q                <= 1'b0;
                            end
                        end
                    end
                    REG_LOCK: begin
                        lock_mask <= lock_new[NUM_ENTRIES-1:0];
                    end
                    REG_KEY_ADDR: begin
                        key_entry  <= key_addr_new[KEY_ENTRY_LSB +: 3];
                        key_offset <= key_addr_new[3:0];
                    end
                    REG_KEY_DATA: begin
                        // next dword of the same entry, wraps at 16
                        key_offset <= key_offset + 4'd1;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // destination buffer, filled only by the read client
    always_ff @(posedge clk) begin
        if (write_en) begin
            dest_buf[write_offset] <= write_data;
        end
    end

    assign dest_off = araddr - REG_DEST_BASE;
    assign dest_hit = (araddr >= REG_DEST_BASE) && (32'(dest_off[AXI_ADDR_W-1:2]) < NUM_DWORDS);

    always_comb begin
        rdata_d = '0;
        if (dest_hit) begin
            rdata_d = dest_buf[dest_off[5:2]];
        end else begin
            case (araddr)
                REG_CTRL:     rdata_d = ctrl_rd;
                REG_LOCK:     rdata_d[NUM_ENTRIES-1:0] = lock_mask;
                REG_KEY_ADDR: rdata_d = key_addr_rd;
                REG_STATUS: begin
                    rdata_d[STATUS_READY_BIT] = kv_ready;
                    rdata_d[STATUS_DONE_BIT] = done_q;
                    rdata_d[STATUS_ERR_LSB +: 8] = error_code;
                end
                default:      rdata_d = '0;
            endcase
        end
    end

    // read data captured at acceptance, held until rready
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rdata_d;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (!rst_b)
        bvalid && !bready |=> bvalid && $stable(bresp)
    );

endmodule

// File: hw/kv_defines_pkg.sv
// key vault definitions
// vault read request and response, read control word,
// error codes and padding constants
package kv_defines_pkg;

    // largest entry, in dwords
    localparam int KV_ENTRY_DWORDS = 16;

    // first dword written once padding starts
    localparam logic [31:0] KV_PAD_WORD = 32'h8000_0000;

    // request from a read client into the vault
    typedef struct packed {
        logic       entry_is_pcr;
        logic [2:0] read_entry;
        logic [3:0] read_offset;
    } kv_read_t;

    // same-cycle answer from the vault
    typedef struct packed {
        logic [31:0] read_data;
        logic        error;
    } kv_rd_resp_t;

    // control word handed to the read client
    // read_en is a single-cycle start pulse
    typedef struct packed {
        logic       read_en;
        logic [2:0] read_entry;
        logic       entry_is_pcr;
        // dword count, used as the pad position
        logic [3:0] entry_data_size;
    } kv_read_ctrl_reg_t;

    typedef enum logic [7:0] {
        KV_SUCCESS   = 8'h00,
        KV_READ_FAIL = 8'h01
    } kv_error_code_e;

endpackage

// File: hw/kv_fsm.sv
// read sequencer
// walks the dword offsets of one block, flags the pad and zero
// offsets when padding is on, and reports ready and done
`timescale 1ns/1ps

module kv_fsm
    import kv_defines_pkg::*;
#(
    parameter int DATA_WIDTH = 384,
    parameter int PAD        = 0
) (
    input  logic        clk,
    input  logic        rst_b,
    input  logic        start,
    input  logic [3:0]  pad_data_size,
    output logic [3:0]  read_offset,
    output logic [3:0]  write_offset,
    output logic        write_en,
    output logic        write_pad,
    output logic [31:0] pad_data,
    output logic        ready,
    output logic        done
);

    localparam int NUM_DWORDS = DATA_WIDTH / 32;
    localparam logic [3:0] LAST_OFFSET = 4'(NUM_DWORDS - 1);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } state_e;

    state_e     state_q;
    logic [3:0] offset_q;
    logic       pad_active;

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state_q  <= IDLE;
            offset_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start) begin
                        state_q  <= RUN;
                        offset_q <= '0;
                    end
                end
                RUN: begin
                    // one dword per cycle, no stalls
                    if (offset_q == LAST_OFFSET) begin
                        state_q  <= DONE;
                        offset_q <= '0;
                    end else begin
                        offset_q <= offset_q + 4'd1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // vault port and buffer share the offset
    assign read_offset  = offset_q;
    assign write_offset = offset_q;
    assign write_en     = (state_q == RUN);
    assign ready        = (state_q == IDLE);
    assign done         = (state_q == DONE);

    // a size that fills the block leaves nothing to pad
    assign pad_active = (PAD == 1) && (32'(pad_data_size) < NUM_DWORDS);
    assign write_pad  = write_en && pad_active && (offset_q >= pad_data_size);

    // marker right after the data, zeros after that
    assign pad_data = (offset_q == pad_data_size) ? KV_PAD_WORD : 32'h0;

    // the register block must hold off starts while a read runs
    a_start_when_ready: assert property (
        @(posedge clk) disable iff (!rst_b)
        start |-> ready
    );

    // a run always covers the full block
    a_full_block: assert property (
        @(posedge clk) disable iff (!rst_b)
        $fell(write_en) |-> $past(write_offset) == LAST_OFFSET
    );

endmodule

// File: hw/kv_read_client.sv
// key vault read client
// turns the control word into vault requests, merges pad dwords
// into the write stream and keeps the error code of the last read
`timescale 1ns/1ps

module kv_read_client
    import kv_defines_pkg::*;
#(
    parameter int DATA_WIDTH = 384,
    parameter int PAD        = 0
) (
    input  logic              clk,
    input  logic              rst_b,
    input  kv_read_ctrl_reg_t read_ctrl_reg,
    output kv_read_t          kv_read,
    input  kv_rd_resp_t       kv_resp,
    output logic              write_en,
    output logic [3:0]        write_offset,
    output logic [31:0]       write_data,
    output kv_error_code_e    error_code,
    output logic              kv_ready,
    output logic              read_done
);

    logic [3:0]  read_offset;
    logic        write_pad;
    logic [31:0] pad_data;

    kv_fsm #(
        .DATA_WIDTH (DATA_WIDTH),
        .PAD        (PAD)
    ) u_read_fsm (
        .clk           (clk),
        .rst_b         (rst_b),
        .start         (read_ctrl_reg.read_en),
        .pad_data_size (read_ctrl_reg.entry_data_size),
        .read_offset   (read_offset),
        .write_offset  (write_offset),
        .write_en      (write_en),
        .write_pad     (write_pad),
        .pad_data      (pad_data),
        .ready         (kv_ready),
        .done          (read_done)
    );

    // entry fields stay put for the whole run
    always_comb begin
        kv_read.entry_is_pcr = read_ctrl_reg.entry_is_pcr;
        kv_read.read_entry   = read_ctrl_reg.read_entry;
        kv_read.read_offset  = read_offset;
    end

    assign write_data = write_pad ? pad_data : kv_resp.read_data;

    // cleared on start, sticks once any dword of the run fails
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            error_code <= KV_SUCCESS;
        end else if (read_ctrl_reg.read_en) begin
            error_code <= KV_SUCCESS;
        end else if (write_en && kv_resp.error) begin
            error_code <= KV_READ_FAIL;
        end
    end

endmodule

// File: hw/kv_reg_pkg.sv
// key vault register map
// word offsets, control and status bit fields, AXI4-Lite responses
package kv_reg_pkg;

    localparam int AXI_ADDR_W = 8;

    localparam logic [AXI_ADDR_W-1:0] REG_CTRL      = 8'h00;
    localparam logic [AXI_ADDR_W-1:0] REG_STATUS    = 8'h04;
    localparam logic [AXI_ADDR_W-1:0] REG_LOCK      = 8'h08;
    localparam logic [AXI_ADDR_W-1:0] REG_KEY_ADDR  = 8'h0C;
    localparam logic [AXI_ADDR_W-1:0] REG_KEY_DATA  = 8'h10;
    localparam logic [AXI_ADDR_W-1:0] REG_DEST_BASE = 8'h40;

    // CTRL fields
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_PCR_BIT   = 1;
    localparam int CTRL_ENTRY_LSB = 4;
    localparam int CTRL_SIZE_LSB  = 8;

    // KEY_ADDR fields, offset sits at bit 0
    localparam int KEY_ENTRY_LSB = 4;

    // STATUS fields
    localparam int STATUS_READY_BIT = 0;
    localparam int STATUS_DONE_BIT  = 1;
    localparam int STATUS_ERR_LSB   = 8;

    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
    localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

// File: hw/kv_store.sv
// key vault storage
// entries of 16 dwords with a lock bit each, combinational read port
// for the read client and a dword write port for host key loading
`timescale 1ns/1ps

module kv_store
    import kv_defines_pkg::*;
#(
    parameter int NUM_ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst_b,
    input  kv_read_t               kv_read,
    output kv_rd_resp_t            kv_resp,
    input  logic                   key_we,
    input  logic [2:0]             key_entry,
    input  logic [3:0]             key_offset,
    input  logic [31:0]            key_data,
    input  logic [NUM_ENTRIES-1:0] lock_mask
);

    logic [31:0] entry_mem [NUM_ENTRIES][KV_ENTRY_DWORDS];
    logic        rd_in_range;
    logic        wr_in_range;
    logic        rd_fail;

    // entry index is 3 bits wide, so compare at full width
    assign rd_in_range = 32'(kv_read.read_entry) < NUM_ENTRIES;
    assign wr_in_range = 32'(key_entry) < NUM_ENTRIES;

    // locked or missing entries read back as an error with zero data
    assign rd_fail = !rd_in_range || lock_mask[kv_read.read_entry];

    always_comb begin
        kv_resp.error     = rd_fail;
        kv_resp.read_data = '0;
        if (!rd_fail) begin
            kv_resp.read_data = entry_mem[kv_read.read_entry][kv_read.read_offset];
        end
    end

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int e = 0; e < NUM_ENTRIES; e++) begin
                for (int d = 0; d < KV_ENTRY_DWORDS; d++) begin
                    entry_mem[e][d] <= '0;
                end
            end
        end else if (key_we && wr_in_range && !lock_mask[key_entry]) begin
            // host writes to a locked entry are dropped
            entry_mem[key_entry][key_offset] <= key_data;
        end
    end

    // a failed read must never leak key material
    a_fail_no_data: assert property (
        @(posedge clk) disable iff (!rst_b)
        kv_resp.error |-> kv_resp.read_data == '0
    );

endmodule

// File: hw/kv_subsys_top.sv
// key vault subsystem top
// AXI4-Lite register block, one read client and the vault storage
`timescale 1ns/1ps

module kv_subsys_top
    import kv_defines_pkg::*;
    import kv_reg_pkg::*;
#(
    parameter int DATA_WIDTH  = 384,
    parameter int PAD         = 1,
    parameter int NUM_ENTRIES = 8
) (
    input  logic                  clk,
    input  logic                  rst_b,
    input  logic [AXI_ADDR_W-1:0] awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [AXI_ADDR_W-1:0] araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    kv_read_ctrl_reg_t      read_ctrl_reg;
    kv_read_t               kv_read;
    kv_rd_resp_t            kv_resp;
    kv_error_code_e         error_code;
    logic                   write_en;
    logic [3:0]             write_offset;
    logic [31:0]            write_data;
    logic                   kv_ready;
    logic                   read_done;
    logic                   key_we;
    logic [2:0]             key_entry;
    logic [3:0]             key_offset;
    logic [31:0]            key_data;
    logic [NUM_ENTRIES-1:0] lock_mask;

    kv_client_regs #(
        .DATA_WIDTH  (DATA_WIDTH),
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_regs (
        .clk           (clk),
        .rst_b         (rst_b),
        .awaddr        (awaddr),
        .awvalid       (awvalid),
        .awready       (awready),
        .wdata         (wdata),
        .wstrb         (wstrb),
        .wvalid        (wvalid),
        .wready        (wready),
        .bresp         (bresp),
        .bvalid        (bvalid),
        .bready        (bready),
        .araddr        (araddr),
        .arvalid       (arvalid),
        .arready       (arready),
        .rdata         (rdata),
        .rresp         (rresp),
        .rvalid        (rvalid),
        .rready        (rready),
        .read_ctrl_reg (read_ctrl_reg),
        .write_en      (write_en),
        .write_offset  (write_offset),
        .write_data    (write_data),
        .error_code    (error_code),
        .kv_ready      (kv_ready),
        .read_done     (read_done),
        .key_we        (key_we),
        .key_entry     (key_entry),
        .key_offset    (key_offset),
        .key_data      (key_data),
        .lock_mask     (lock_mask)
    );

    kv_read_client #(
        .DATA_WIDTH (DATA_WIDTH),
        .PAD        (PAD)
    ) u_read_client (
        .clk           (clk),
        .rst_b         (rst_b),
        .read_ctrl_reg (read_ctrl_reg),
        .kv_read       (kv_read),
        .kv_resp       (kv_resp),
        .write_en      (write_en),
        .write_offset  (write_offset),
        .write_data    (write_data),
        .error_code    (error_code),
        .kv_ready      (kv_ready),
        .read_done     (read_done)
    );

    kv_store #(
        .NUM_ENTRIES (NUM_ENTRIES)
    ) u_store (
        .clk        (clk),
        .rst_b      (rst_b),
        .kv_read    (kv_read),
        .kv_resp    (kv_resp),
        .key_we     (key_we),
        .key_entry  (key_entry),
        .key_offset (key_offset),
        .key_data   (key_data),
        .lock_mask  (lock_mask)
    );

endmodule

// File: run.sh
#!/bin/sh
# builds the key vault testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module kv_subsys_tb -f files.f -o kv_sim

out=$(./obj_dir/kv_sim)
echo "$out"

# pass only when the testbench printed its pass line
echo "$out" | grep -q "^=== PASS ===$"

// File: tests/kv_subsys_tb.sv
// key vault subsystem testbench
// directed tests over AXI4-Lite: key load, padded and full reads,
// locked entries, busy control writes and response back-pressure
`timescale 1ns/1ps

module kv_subsys_tb
    import kv_defines_pkg::*;
    import kv_reg_pkg::*;
();

    localparam int DATA_WIDTH     = 384;
    localparam int PAD            = 1;
    localparam int NUM_ENTRIES    = 8;
    localparam int NUM_DWORDS     = DATA_WIDTH / 32;
    // roughly 5 cycles per register access, the locked entry test is the longest
    localparam int TEST_BUDGET    = 400;
    localparam int NUM_TESTS      = 7;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * TEST_BUDGET + 1000;

    logic                  clk;
    logic                  rst_b;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    // reference copy of the vault
    logic [31:0]            model_mem [NUM_ENTRIES][KV_ENTRY_DWORDS];
    logic [NUM_ENTRIES-1:0] model_lock;

    logic [31:0] lcg_state = 32'h3427_5192;
    int          data_errors = 0;
    int          code_errors = 0;
    int          resp_errors = 0;
    int          cycle_count = 0;

    kv_tb_clk u_clk (
        .clk   (clk),
        .rst_b (rst_b)
    );

    kv_subsys_top #(
        .DATA_WIDTH  (DATA_WIDTH),
        .PAD         (PAD),
        .NUM_ENTRIES (NUM_ENTRIES)
    ) DUT (
        .clk     (clk),
        .rst_b   (rst_b),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // expected buffer dword from the padding and error rules
    function automatic logic [31:0] expected_dword(input logic [2:0] entry,
                                                   input logic [3:0] size,
                                                   input int idx,
                                                   input logic fail);
        if (PAD == 1 && int'(size) < NUM_DWORDS && idx >= int'(size)) begin
            return (idx == int'(size)) ? KV_PAD_WORD : 32'h0;
        end
        return fail ? 32'h0 : model_mem[entry][idx];
    endfunction

    task automatic check_data(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            data_errors++;
            $display("CHECK FAILED at %0t: %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_error(input string name, input kv_error_code_e got,
                               input kv_error_code_e exp);
        if (got !== exp) begin
            code_errors++;
            $display("CHECK FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_resp(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            resp_errors++;
            $display("CHECK FAILED at %0t: %s got %0b expected %0b", $time, name, got, exp);
        end
    endtask

    // outputs sampled on the falling edge, inputs changed on the rising edge
    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                             input int hold, output logic [1:0] resp);
        logic [1:0] first_resp;
        @(posedge clk);
        awaddr  <= addr;
        wdata   <= data;
        wstrb   <= 4'hf;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        do begin
            @(negedge clk);
        end while (!awready);
        check_data("wready", 32'(wready), 32'd1);
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do begin
            @(negedge clk);
        end while (!bvalid);
        first_resp = bresp;
        // bready held low for a while
        repeat (hold) begin
            @(negedge clk);
            check_data("bvalid held", 32'(bvalid), 32'd1);
            check_resp("bresp held", bresp, first_resp);
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        bready <= 1'b0;
        resp = first_resp;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, input int hold,
                            output logic [31:0] data, output logic [1:0] resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do begin
            @(negedge clk);
        end while (!arready);
        @(posedge clk);
        arvalid <= 1'b0;
        do begin
            @(negedge clk);
        end while (!rvalid);
        data = rdata;
        resp = rresp;
        repeat (hold) begin
            @(negedge clk);
            check_data("rvalid held", 32'(rvalid), 32'd1);
            check_data("rdata held", rdata, data);
            check_resp("rresp held", rresp, resp);
        end
        @(posedge clk);
        rready <= 1'b1;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic reg_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
        logic [1:0] resp;
        axi_write(addr, data, 0, resp);
        check_resp("bresp", resp, AXI_RESP_OKAY);
    endtask

    task automatic reg_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
        logic [1:0] resp;
        axi_read(addr, 0, data, resp);
        check_resp("rresp", resp, AXI_RESP_OKAY);
    endtask

    // fills all 16 dwords of one entry through the auto-increment port
    task automatic load_entry(input logic [2:0] entry);
        logic [31:0] val;
        reg_write(REG_KEY_ADDR, {25'd0, entry, 4'd0});
        for (int d = 0; d < KV_ENTRY_DWORDS; d++) begin
            val = lcg_next();
            reg_write(REG_KEY_DATA, val);
            if (!model_lock[entry]) begin
                model_mem[entry][d] = val;
            end
        end
    endtask

    task automatic set_lock(input logic [NUM_ENTRIES-1:0] mask);
        reg_write(REG_LOCK, 32'(mask));
        model_lock = mask;
    endtask

    task automatic start_read(input logic [3:0] entry, input logic [3:0] size);
        reg_write(REG_CTRL, (32'(size) << CTRL_SIZE_LSB) | (32'(entry) << CTRL_ENTRY_LSB)
                            | 32'd1);
    endtask

    task automatic wait_done(output logic [31:0] status);
        do begin
            reg_read(REG_STATUS, status);
        end while (!status[STATUS_DONE_BIT]);
    endtask

    // status and whole buffer of a finished read
    task automatic check_block(input logic [3:0] entry_req, input logic [3:0] size);
        logic [31:0]    status;
        logic [31:0]    got;
        logic [2:0]     entry;
        logic           fail;
        kv_error_code_e exp_err;
        // CTRL keeps only 3 entry bits
        entry   = entry_req[2:0];
        fail    = (int'(entry) >= NUM_ENTRIES) || model_lock[entry];
        exp_err = fail ? KV_READ_FAIL : KV_SUCCESS;
        wait_done(status);
        check_data("status.ready", 32'(status[STATUS_READY_BIT]), 32'd1);
        check_error("status.error", kv_error_code_e'(status[STATUS_ERR_LSB +: 8]), exp_err);
        for (int i = 0; i < NUM_DWORDS; i++) begin
            reg_read(REG_DEST_BASE + AXI_ADDR_W'(4 * i), got);
            check_data($sformatf("dest[%0d]", i), got, expected_dword(entry, size, i, fail));
        end
    endtask

    task automatic read_and_check(input logic [3:0] entry, input logic [3:0] size);
        start_read(entry, size);
        check_block(entry, size);
    endtask

    task automatic check_reset_state();
        logic [31:0] status;
        $display("reset state");
        @(negedge clk);
        check_data("bvalid", 32'(bvalid), 32'd0);
        check_data("rvalid", 32'(rvalid), 32'd0);
        reg_read(REG_STATUS, status);
        check_data("status.ready", 32'(status[STATUS_READY_BIT]), 32'd1);
        check_data("status.done", 32'(status[STATUS_DONE_BIT]), 32'd0);
        check_error("status.error", kv_error_code_e'(status[STATUS_ERR_LSB +: 8]), KV_SUCCESS);
    endtask

    task automatic test_padded_read();
        $display("test 1: padded read of entry 2");
        load_entry(3'd2);
        read_and_check(4'd2, 4'd5);
    endtask

    task automatic test_full_read();
        $display("test 2: full read of entry 2");
        read_and_check(4'd2, 4'd12);
    endtask

    task automatic test_locked_entry();
        $display("test 3: locked entry");
        load_entry(3'd4);
        set_lock(8'h10);
        read_and_check(4'd4, 4'd3);
        // dropped by the vault, model left alone
        reg_write(REG_KEY_ADDR, {25'd0, 3'd4, 4'd0});
        reg_write(REG_KEY_DATA, lcg_next());
        set_lock(8'h00);
        read_and_check(4'd4, 4'd12);
    endtask

    task automatic test_entry_index_wrap();
        $display("test 4: failing read then good read");
        load_entry(3'd1);
        set_lock(8'h40);
        read_and_check(4'd6, 4'd4);
        set_lock(8'h00);
        // index 9 lands on entry 1 since the field is 3 bits and all 8 entries exist
        read_and_check(4'd9, 4'd4);
    endtask

    task automatic test_busy_ctrl_write();
        logic [1:0]  resp;
        logic [31:0] ctrl;
        $display("test 5: CTRL write during a read");
        start_read(4'd2, 4'd7);
        axi_write(REG_CTRL, (32'd3 << CTRL_SIZE_LSB) | (32'd4 << CTRL_ENTRY_LSB) | 32'd1,
                  0, resp);
        check_resp("busy CTRL bresp", resp, AXI_RESP_SLVERR);
        check_block(4'd2, 4'd7);
        reg_read(REG_CTRL, ctrl);
        check_data("ctrl", ctrl, (32'd7 << CTRL_SIZE_LSB) | (32'd2 << CTRL_ENTRY_LSB));
    endtask

    task automatic test_backpressure();
        logic [1:0]  resp;
        logic [31:0] data;
        $display("test 6: response back-pressure");
        axi_write(REG_LOCK, 32'h0000_0081, 6, resp);
        check_resp("held bresp", resp, AXI_RESP_OKAY);
        model_lock = 8'h81;
        axi_read(REG_LOCK, 6, data, resp);
        check_resp("held rresp", resp, AXI_RESP_OKAY);
        check_data("lock", data, 32'h0000_0081);
        set_lock(8'h00);
        // buffer still holds the entry 2 read of test 5
        axi_read(REG_DEST_BASE + AXI_ADDR_W'(4 * 5), 5, data, resp);
        check_resp("held rresp", resp, AXI_RESP_OKAY);
        check_data("held dest[5]", data, expected_dword(3'd2, 4'd7, 5, 1'b0));
    endtask

    // run limit
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("=== FAIL ===");
            $finish;
        end
    end

    initial begin
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        model_lock = '0;
        for (int e = 0; e < NUM_ENTRIES; e++) begin
            for (int d = 0; d < KV_ENTRY_DWORDS; d++) begin
                model_mem[e][d] = 32'h0;
            end
        end
        wait (rst_b === 1'b1);
        repeat (2) @(posedge clk);
        check_reset_state();
        test_padded_read();
        test_full_read();
        test_locked_entry();
        test_entry_index_wrap();
        test_busy_ctrl_write();
        test_backpressure();
        $display("errors: data %0d, error code %0d, response %0d",
                 data_errors, code_errors, resp_errors);
        if (data_errors + code_errors + resp_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tests/kv_tb_clk.sv
// testbench clock and reset
// 4 ns clock, reset held low for the first 4 cycles
`timescale 1ns/1ps

module kv_tb_clk (
    output logic clk,
    output logic rst_b
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_b = 1'b0;
        repeat (4) @(posedge clk);
        rst_b <= 1'b1;
    end

endmodule
